/* Makefile */
TOP = tb_ads111x

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Test failed" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

/* logic/ads111x_ctrl.sv */
//==================================================
// ADS1115 I2C master controller top
// Sequencer, byte engine and register mirror
//==================================================
`timescale 1ns/100ps
`default_nettype none

module ads111x_ctrl (
	input wire sys_clk,
	input wire sys_nrst,
	input wire start,
	input wire ads_pkg::ads_cmd_t cmd,
	input wire sda_in,
	output logic ready,
	output logic done,
	output logic nack_err,
	output ads_pkg::ads_regs_t regs,
	output logic scl,
	output logic sda_oe
);

	// Sequencer to byte engine
	logic byte_valid;
	ads_pkg::byte_req_t byte_req;
	logic byte_busy;
	logic byte_done;
	ads_pkg::i2c_byte_t rx_byte;
	logic ack_seen;

	// Sequencer to mirror
	logic rd_valid;
	ads_pkg::ads_word_t rd_word;
	ads_pkg::ads_ptr_e rd_ptr;

	ads_txn_fsm u_fsm (
		.sys_clk (sys_clk),
		.sys_nrst (sys_nrst),
		.start (start),
		.cmd (cmd),
		.byte_busy (byte_busy),
		.byte_done (byte_done),
		.rx_byte (rx_byte),
		.ack_seen (ack_seen),
		.ready (ready),
		.done (done),
		.nack_err (nack_err),
		.byte_valid (byte_valid),
		.byte_req (byte_req),
		.rd_valid (rd_valid),
		.rd_word (rd_word),
		.rd_ptr (rd_ptr)
	);

	i2c_byte_engine u_engine (
		.sys_clk (sys_clk),
		.sys_nrst (sys_nrst),
		.byte_valid (byte_valid),
		.byte_req (byte_req),
		.sda_in (sda_in),
		.byte_busy (byte_busy),
		.byte_done (byte_done),
		.rx_byte (rx_byte),
		.ack_seen (ack_seen),
		.scl (scl),
		.sda_out_en (sda_oe)
	);

	ads_reg_mirror u_mirror (
		.sys_clk (sys_clk),
		.sys_nrst (sys_nrst),
		.rd_valid (rd_valid),
		.rd_word (rd_word),
		.rd_ptr (rd_ptr),
		.regs (regs)
	);

endmodule

`default_nettype wire

/* logic/ads_pkg.sv */
//==================================================
// ADS1115 controller shared definitions
// Bus timing, device address, register layouts
// and the command, request and result structs
//==================================================
`default_nettype none

package ads_pkg;

	//==================================================
	// Bus timing
	//==================================================
	localparam int SYS_CLK_HZ = 125_000_000;
	localparam int I2C_BPS = 1_000_000;
	// Each SCL bit is split into five equal steps
	localparam int PHASE_CYCLES = SYS_CLK_HZ / I2C_BPS / 5;

	// ADDR pin tied to ground
	localparam logic [6:0] DEV_ADDR = 7'b1001000;

	//==================================================
	// Register types
	//==================================================
	typedef logic [15:0] ads_word_t;
	typedef logic [7:0] i2c_byte_t;

	// Pointer byte low bits select one of four registers
	typedef enum logic [1:0] {
		conv = 2'd0,
		cfg = 2'd1,
		lo_thr = 2'd2,
		hi_thr = 2'd3
	} ads_ptr_e;

	// Config register, MSB first as on the wire
	typedef struct packed {
		logic os;
		logic [2:0] mux;
		logic [2:0] pga;
		logic mode;
		logic [2:0] dr;
		logic comp_mode;
		logic comp_pol;
		logic comp_lat;
		logic [1:0] comp_que;
	} ads_config_t;

	// Device power-up values
	localparam ads_word_t CONFIG_RESET = 16'h8583;
	localparam ads_word_t LO_THR_RESET = 16'h8000;
	localparam ads_word_t HI_THR_RESET = 16'h7FFF;

	// Host command, rw is 1 for a read
	typedef struct packed {
		logic rw;
		ads_ptr_e ptr;
		logic ptr_only;
		ads_word_t wdata;
	} ads_cmd_t;

	typedef struct packed {
		ads_word_t conv;
		ads_config_t cfg;
		ads_word_t lo_thr;
		ads_word_t hi_thr;
	} ads_regs_t;

	//==================================================
	// Byte engine request
	//==================================================
	typedef enum logic [2:0] {
		start,
		write,
		read_ack,
		read_nack,
		stop
	} byte_op_e;

	typedef struct packed {
		byte_op_e op;
		i2c_byte_t tx;
	} byte_req_t;

endpackage

`default_nettype wire

/* logic/ads_reg_mirror.sv */
//==================================================
// ADS1115 register mirror
// Host copies of the four device registers
//==================================================
`timescale 1ns/100ps
`default_nettype none

module ads_reg_mirror (
	input wire sys_clk,
	input wire sys_nrst,
	input wire rd_valid,
	input wire ads_pkg::ads_word_t rd_word,
	input wire ads_pkg::ads_ptr_e rd_ptr,
	output ads_pkg::ads_regs_t regs
);

	// Starts from the device power-up contents
	always_ff @(posedge sys_clk or negedge sys_nrst) begin
		if (!sys_nrst) begin
			regs.conv <= '0;
			regs.cfg <= ads_pkg::ads_config_t'(ads_pkg::CONFIG_RESET);
			regs.lo_thr <= ads_pkg::LO_THR_RESET;
			regs.hi_thr <= ads_pkg::HI_THR_RESET;
		end else if (rd_valid) begin
			case (rd_ptr)
				ads_pkg::conv: regs.conv <= rd_word;
				ads_pkg::cfg: regs.cfg <= ads_pkg::ads_config_t'(rd_word);
				ads_pkg::lo_thr: regs.lo_thr <= rd_word;
				ads_pkg::hi_thr: regs.hi_thr <= rd_word;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/ads_txn_fsm.sv */
//==================================================
// ADS1115 transaction sequencer
// Turns one host command into byte engine steps
//==================================================
`timescale 1ns/100ps
`default_nettype none

module ads_txn_fsm (
	input wire sys_clk,
	input wire sys_nrst,
	input wire start,
	input wire ads_pkg::ads_cmd_t cmd,
	input wire byte_busy,
	input wire byte_done,
	input wire ads_pkg::i2c_byte_t rx_byte,
	input wire ack_seen,
	output logic ready,
	output logic done,
	output logic nack_err,
	output logic byte_valid,
	output ads_pkg::byte_req_t byte_req,
	output logic rd_valid,
	output ads_pkg::ads_word_t rd_word,
	output ads_pkg::ads_ptr_e rd_ptr
);

	typedef enum logic [3:0] {
		st_idle, st_start, st_addr, st_ptr, st_data_hi,
		st_data_lo, st_rd_hi, st_rd_lo, st_stop, st_done
	} txn_state_e;

	txn_state_e state;
	txn_state_e nxt_state;
	ads_pkg::ads_cmd_t cmd_q;
	ads_pkg::byte_req_t nxt_req;
	logic accept;
	logic miss_ack;
	logic err_q;

	assign accept = start && ready;
	assign miss_ack = !ack_seen && (state == st_addr || state == st_ptr ||
		state == st_data_hi || state == st_data_lo);
	// Mirror sees the read word one cycle ahead of done
	assign rd_valid = (state == st_stop) && byte_done && cmd_q.rw && !err_q;

	//==================================================
	// Next operation after the one in flight
	//==================================================
	always_comb begin
		nxt_state = st_stop;
		nxt_req.op = ads_pkg::stop;
		nxt_req.tx = '0;
		if (!miss_ack) begin
			case (state)
				st_start: begin
					nxt_state = st_addr;
					nxt_req.op = ads_pkg::write;
					nxt_req.tx = {ads_pkg::DEV_ADDR, cmd_q.rw};
				end
				st_addr: begin
					if (cmd_q.rw) begin
						nxt_state = st_rd_hi;
						nxt_req.op = ads_pkg::read_ack;
					end else begin
						nxt_state = st_ptr;
						nxt_req.op = ads_pkg::write;
						nxt_req.tx = {6'b000000, cmd_q.ptr};
					end
				end
				st_ptr: begin
					if (!cmd_q.ptr_only) begin
						nxt_state = st_data_hi;
						nxt_req.op = ads_pkg::write;
						nxt_req.tx = cmd_q.wdata[15:8];
					end
				end
				st_data_hi: begin
					nxt_state = st_data_lo;
					nxt_req.op = ads_pkg::write;
					nxt_req.tx = cmd_q.wdata[7:0];
				end
				// Last byte is not acknowledged
				st_rd_hi: begin
					nxt_state = st_rd_lo;
					nxt_req.op = ads_pkg::read_nack;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge sys_clk or negedge sys_nrst) begin
		if (!sys_nrst) begin
			state <= st_idle;
			ready <= 1'b1;
			done <= 1'b0;
			nack_err <= 1'b0;
			err_q <= 1'b0;
			byte_valid <= 1'b0;
			rd_ptr <= ads_pkg::conv;
		end else begin
			done <= 1'b0;
			if (byte_valid && !byte_busy)
				byte_valid <= 1'b0;
			case (state)
				st_idle: if (accept) begin
					state <= st_start;
					ready <= 1'b0;
					err_q <= 1'b0;
					byte_valid <= 1'b1;
				end
				st_stop: if (byte_done) begin
					state <= st_done;
					done <= 1'b1;
					nack_err <= err_q;
				end
				st_done: begin
					state <= st_idle;
					ready <= 1'b1;
				end
				default: if (byte_done) begin
					state <= nxt_state;
					byte_valid <= 1'b1;
					if (miss_ack)
						err_q <= 1'b1;
					// Device pointer moves once the pointer byte is acked
					if (state == st_ptr && !miss_ack)
						rd_ptr <= cmd_q.ptr;
				end
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			cmd_q <= cmd;
			byte_req.op <= ads_pkg::start;
			byte_req.tx <= '0;
		end else if (byte_done) begin
			byte_req <= nxt_req;
		end
		if (byte_done && (state == st_rd_hi || state == st_rd_lo))
			rd_word <= {rd_word[7:0], rx_byte};
	end

endmodule

`default_nettype wire

/* logic/i2c_byte_engine.sv */
//==================================================
// I2C bit timing and byte shifter
// Runs START, STOP and 9-bit byte slots with ack
//==================================================
`timescale 1ns/100ps
`default_nettype none

module i2c_byte_engine (
	input wire sys_clk,
	input wire sys_nrst,
	input wire byte_valid,
	input wire ads_pkg::byte_req_t byte_req,
	input wire sda_in,
	output logic byte_busy,
	output logic byte_done,
	output ads_pkg::i2c_byte_t rx_byte,
	output logic ack_seen,
	output logic scl,
	output logic sda_out_en
);

	logic [$clog2(ads_pkg::PHASE_CYCLES)-1:0] tick_cnt;
	logic [2:0] step;
	logic [3:0] bit_cnt;
	ads_pkg::byte_op_e op_q;
	ads_pkg::i2c_byte_t shreg;
	logic tick_end;
	logic last_bit;
	logic byte_op;

	// Line levels on entry to a step, returned as {scl, sda pull-down}
	function automatic logic [1:0] line_state(ads_pkg::byte_op_e op, logic [2:0] stp,
		logic ack_bit, logic data_bit, logic cur_oe);
		logic scl_v;
		logic oe_v;
		scl_v = (stp == 3'd1) || (stp == 3'd2);
		oe_v = cur_oe;
		case (op)
			// SDA falls while SCL is high, then SCL drops
			ads_pkg::start: begin
				scl_v = (stp != 3'd4);
				oe_v = (stp != 3'd0);
			end
			// SDA rises while SCL is high
			ads_pkg::stop: begin
				scl_v = (stp != 3'd0);
				oe_v = (stp != 3'd4);
			end
			ads_pkg::write: if (stp == 3'd0) oe_v = !ack_bit && !data_bit;
			ads_pkg::read_ack: if (stp == 3'd0) oe_v = ack_bit;
			default: if (stp == 3'd0) oe_v = 1'b0;
		endcase
		return {scl_v, oe_v};
	endfunction

	assign tick_end = (tick_cnt == $bits(tick_cnt)'(ads_pkg::PHASE_CYCLES - 1));
	assign byte_op = (op_q != ads_pkg::start) && (op_q != ads_pkg::stop);
	// START and STOP are a single slot, bytes have nine
	assign last_bit = byte_op ? (bit_cnt == 4'd8) : (bit_cnt == 4'd0);
	assign rx_byte = shreg;

	//==================================================
	// Phase timer and line control
	//==================================================
	always_ff @(posedge sys_clk or negedge sys_nrst) begin
		if (!sys_nrst) begin
			byte_busy <= 1'b0;
			byte_done <= 1'b0;
			tick_cnt <= '0;
			step <= 3'd0;
			bit_cnt <= 4'd0;
			op_q <= ads_pkg::stop;
			scl <= 1'b1;
			sda_out_en <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			if (!byte_busy) begin
				if (byte_valid) begin
					byte_busy <= 1'b1;
					op_q <= byte_req.op;
					tick_cnt <= '0;
					step <= 3'd0;
					bit_cnt <= 4'd0;
					{scl, sda_out_en} <= line_state(byte_req.op, 3'd0, 1'b0,
						byte_req.tx[7], sda_out_en);
				end
			end else if (!tick_end) begin
				tick_cnt <= tick_cnt + 1'b1;
			end else begin
				tick_cnt <= '0;
				if (step != 3'd4) begin
					step <= step + 3'd1;
					{scl, sda_out_en} <= line_state(op_q, step + 3'd1, bit_cnt == 4'd8,
						shreg[7], sda_out_en);
				end else if (last_bit) begin
					byte_busy <= 1'b0;
					byte_done <= 1'b1;
				end else begin
					step <= 3'd0;
					bit_cnt <= bit_cnt + 4'd1;
					// Shifter already holds the next bit in its MSB
					{scl, sda_out_en} <= line_state(op_q, 3'd0, bit_cnt == 4'd7,
						shreg[7], sda_out_en);
				end
			end
		end
	end

	// Sample in the middle of SCL high, end of step 1
	always_ff @(posedge sys_clk) begin
		if (!byte_busy && byte_valid) begin
			shreg <= byte_req.tx;
		end else if (byte_busy && byte_op && tick_end && step == 3'd1) begin
			if (bit_cnt == 4'd8)
				ack_seen <= !sda_in;
			else
				shreg <= {shreg[6:0], sda_in};
		end
	end

endmodule

`default_nettype wire

/* tb/ads_slave_model.sv */
//==================================================
// ADS1115 bus slave model
// Register file with pointer, ack and read-back
//==================================================
`timescale 1ns/100ps
`default_nettype none

module ads_slave_model (
	input wire scl,
	input wire sda_oe,
	input wire absent,
	output wire sda
);

	logic [15:0] regs [0:3];
	logic slave_oe;
	logic active;
	logic in_bit;
	logic addressed;
	logic reading;
	logic sending;
	logic master_ack;
	logic [3:0] bit_cnt;
	logic [2:0] byte_idx;
	logic [1:0] ptr;
	logic [7:0] shift_in;
	logic [7:0] tx;
	logic [7:0] hi_byte;

	// Open-drain line with pull-up
	assign sda = !(sda_oe || slave_oe);

	initial begin
		regs[0] = 16'h1234;
		regs[1] = 16'h8583;
		regs[2] = 16'h8000;
		regs[3] = 16'h7FFF;
		slave_oe = 1'b0;
		active = 1'b0;
		in_bit = 1'b0;
		addressed = 1'b0;
		reading = 1'b0;
		sending = 1'b0;
		master_ack = 1'b0;
		bit_cnt = 4'd0;
		byte_idx = 3'd0;
		ptr = 2'd0;
		shift_in = 8'h00;
		tx = 8'h00;
		hi_byte = 8'h00;
	end

	// START
	always @(negedge sda) begin
		if (scl) begin
			active = 1'b1;
			in_bit = 1'b0;
			addressed = 1'b0;
			sending = 1'b0;
			bit_cnt = 4'd0;
			byte_idx = 3'd0;
		end
	end

	// STOP
	always @(posedge sda) begin
		if (scl) begin
			active = 1'b0;
			sending = 1'b0;
			slave_oe = 1'b0;
		end
	end

	always @(posedge scl) begin
		if (active) begin
			in_bit = 1'b1;
			if (bit_cnt < 4'd8)
				shift_in = {shift_in[6:0], sda};
			else if (sending)
				master_ack = !sda;
		end
	end

	// SDA only moves while SCL is low
	always @(negedge scl) begin
		if (active && in_bit) begin
			in_bit = 1'b0;
			if (bit_cnt == 4'd7) begin
				bit_cnt = 4'd8;
				if (!sending) begin
					if (byte_idx == 3'd0) begin
						addressed = (shift_in[7:1] == ads_pkg::DEV_ADDR) && !absent;
						reading = shift_in[0];
					end else if (addressed) begin
						case (byte_idx)
							3'd1: ptr = shift_in[1:0];
							3'd2: hi_byte = shift_in;
							3'd3: regs[ptr] = {hi_byte, shift_in};
							default: ;
						endcase
					end
					slave_oe = addressed;
				end else begin
					slave_oe = 1'b0;
				end
			end else if (bit_cnt == 4'd8) begin
				bit_cnt = 4'd0;
				sending = addressed && reading && (byte_idx == 3'd0 || master_ack);
				byte_idx = byte_idx + 3'd1;
				if (sending) begin
					tx = (byte_idx == 3'd1) ? regs[ptr][15:8] : regs[ptr][7:0];
					slave_oe = !tx[7];
				end else begin
					slave_oe = 1'b0;
				end
			end else begin
				bit_cnt = bit_cnt + 4'd1;
				if (sending) begin
					tx = {tx[6:0], 1'b0};
					slave_oe = !tx[7];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* tb/ads_trace.txt */
// count, then: rw ptr ptr_only wdata slave_absent exp_word exp_nack
// ptr 0 conv, 1 config, 2 lo_thr, 3 hi_thr, all values hex
000d
0 1 0 c3e3 0 0000 0
1 1 0 0000 0 c3e3 0
0 2 0 1a2b 0 0000 0
0 3 0 7e5d 0 0000 0
0 2 1 0000 0 0000 0
1 2 0 0000 0 1a2b 0
0 3 1 0000 0 0000 0
1 3 0 0000 0 7e5d 0
0 0 1 0000 0 0000 0
1 0 0 0000 0 1234 0
0 1 0 0f0f 1 0000 1
1 0 0 0000 1 0000 1
1 0 0 0000 0 1234 0

/* tb/tb_ads111x.sv */
//==================================================
// ADS1115 controller testbench
// Trace driven commands against a bus slave model
//==================================================
`timescale 1ns/100ps
`default_nettype none

module tb_ads111x;

	localparam int REC_LEN = 7;

	logic sys_clk;
	logic sys_nrst;
	logic start;
	ads_pkg::ads_cmd_t cmd;
	logic slave_absent;
	logic ready;
	logic done;
	logic nack_err;
	ads_pkg::ads_regs_t regs;
	logic scl;
	logic sda_oe;
	wire sda_line;

	logic [15:0] trace_mem [0:255];
	logic [31:0] rng;
	ads_pkg::ads_regs_t exp_regs;
	int done_cnt;

	ads111x_ctrl dut_i (
		.sys_clk (sys_clk),
		.sys_nrst (sys_nrst),
		.start (start),
		.cmd (cmd),
		.sda_in (sda_line),
		.ready (ready),
		.done (done),
		.nack_err (nack_err),
		.regs (regs),
		.scl (scl),
		.sda_oe (sda_oe)
	);

	ads_slave_model slave_i (
		.scl (scl),
		.sda_oe (sda_oe),
		.absent (slave_absent),
		.sda (sda_line)
	);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = !sys_clk;
	end

	// Counts the pulse of the cycle just ending
	always @(posedge sys_clk) begin
		if (sys_nrst && done)
			done_cnt = done_cnt + 1;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic report_mismatch(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		$display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
		abort_run();
	endtask

	task automatic check_word(input string name, input ads_pkg::ads_word_t got,
		input ads_pkg::ads_word_t exp);
		if (got !== exp)
			report_mismatch(name, got, exp);
	endtask

	task automatic check_config(input ads_pkg::ads_config_t got,
		input ads_pkg::ads_config_t exp);
		if (got.os !== exp.os) report_mismatch("regs.cfg.os", 16'(got.os), 16'(exp.os));
		if (got.mux !== exp.mux) report_mismatch("regs.cfg.mux", 16'(got.mux), 16'(exp.mux));
		if (got.pga !== exp.pga) report_mismatch("regs.cfg.pga", 16'(got.pga), 16'(exp.pga));
		if (got.mode !== exp.mode)
			report_mismatch("regs.cfg.mode", 16'(got.mode), 16'(exp.mode));
		if (got.dr !== exp.dr) report_mismatch("regs.cfg.dr", 16'(got.dr), 16'(exp.dr));
		if (got.comp_mode !== exp.comp_mode)
			report_mismatch("regs.cfg.comp_mode", 16'(got.comp_mode), 16'(exp.comp_mode));
		if (got.comp_pol !== exp.comp_pol)
			report_mismatch("regs.cfg.comp_pol", 16'(got.comp_pol), 16'(exp.comp_pol));
		if (got.comp_lat !== exp.comp_lat)
			report_mismatch("regs.cfg.comp_lat", 16'(got.comp_lat), 16'(exp.comp_lat));
		if (got.comp_que !== exp.comp_que)
			report_mismatch("regs.cfg.comp_que", 16'(got.comp_que), 16'(exp.comp_que));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_mismatch(name, 16'(got), 16'(exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Wrong number of %s pulses, saw %0d instead of %0d", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_mirror();
		check_word("regs.conv", regs.conv, exp_regs.conv);
		check_config(regs.cfg, exp_regs.cfg);
		check_word("regs.lo_thr", regs.lo_thr, exp_regs.lo_thr);
		check_word("regs.hi_thr", regs.hi_thr, exp_regs.hi_thr);
	endtask

	// One trace record, start to done
	task automatic run_txn(input int idx);
		int base;
		logic exp_nack;
		base = 1 + idx * REC_LEN;
		exp_nack = trace_mem[base + 6][0];
		@(posedge sys_clk);
		cmd.rw <= trace_mem[base][0];
		cmd.ptr <= ads_pkg::ads_ptr_e'(trace_mem[base + 1][1:0]);
		cmd.ptr_only <= trace_mem[base + 2][0];
		cmd.wdata <= trace_mem[base + 3];
		slave_absent <= trace_mem[base + 4][0];
		start <= 1'b1;
		@(posedge sys_clk);
		start <= 1'b0;
		@(negedge sys_clk);
		check_flag("ready", ready, 1'b0);
		while (!done)
			@(negedge sys_clk);
		if (trace_mem[base][0] && !exp_nack) begin
			case (trace_mem[base + 1][1:0])
				2'd0: exp_regs.conv = trace_mem[base + 5];
				2'd1: exp_regs.cfg = ads_pkg::ads_config_t'(trace_mem[base + 5]);
				2'd2: exp_regs.lo_thr = trace_mem[base + 5];
				default: exp_regs.hi_thr = trace_mem[base + 5];
			endcase
		end
		check_flag("nack_err", nack_err, exp_nack);
		check_mirror();
		@(negedge sys_clk);
		check_flag("ready", ready, 1'b1);
		check_flag("done", done, 1'b0);
		check_count("done", done_cnt, idx + 1);
	endtask

	//==================================================
	// Main sequence
	//==================================================
	initial begin
		int n_txn;
		int gap;
		sys_nrst = 1'b0;
		start = 1'b0;
		cmd = '0;
		slave_absent = 1'b0;
		done_cnt = 0;
		rng = 32'hf420e278;
		$readmemh("tb/ads_trace.txt", trace_mem);
		n_txn = int'(trace_mem[0]);
		// ADS1115 power-up register contents
		exp_regs.conv = 16'h0000;
		exp_regs.cfg = ads_pkg::ads_config_t'(16'h8583);
		exp_regs.lo_thr = 16'h8000;
		exp_regs.hi_thr = 16'h7FFF;
		repeat (4) @(posedge sys_clk);
		sys_nrst <= 1'b1;
		@(negedge sys_clk);
		check_flag("ready", ready, 1'b1);
		check_flag("done", done, 1'b0);
		check_flag("nack_err", nack_err, 1'b0);
		check_flag("scl", scl, 1'b1);
		check_flag("sda_oe", sda_oe, 1'b0);
		check_mirror();
		for (int i = 0; i < n_txn; i++) begin
			rng = xorshift32(rng);
			gap = int'(rng[2:0]);
			repeat (gap) @(posedge sys_clk);
			run_txn(i);
		end
		$display("Test completed successfully");
		$finish;
	end

	// Watchdog, budget scales with the trace length
	initial begin
		int limit;
		#1;
		limit = int'(trace_mem[0]) * 60 * 45 * ads_pkg::PHASE_CYCLES + 100;
		repeat (limit) @(posedge sys_clk);
		$display("Run timed out waiting for the controller to finish");
		abort_run();
	end

endmodule

`default_nettype wire

/* vlog.f */
logic/ads_pkg.sv
logic/i2c_byte_engine.sv
logic/ads_txn_fsm.sv
logic/ads_reg_mirror.sv
logic/ads111x_ctrl.sv
tb/ads_slave_model.sv
tb/tb_ads111x.sv
